/* include/ti_defs.svh */
// matrix size, reset hold length and field widths; ps2 event bits must agree with ps2_event_t in ti_pkg
`ifndef TI_DEFS_SVH
`define TI_DEFS_SVH

// ===================================================================
// keyboard matrix
// ===================================================================

`define TI_KB_LINES 8 // rows and columns of the console matrix

// ===================================================================
// reset sequencing
// ===================================================================

`define TI_HOLD_CYCLES 255 // flash loading hold after the last request
`define TI_HOLD_W 8 // hold counter width, must cover TI_HOLD_CYCLES

// ===================================================================
// pad widths
// ===================================================================

`define TI_JOY_W 12 // usb pad word
`define TI_DB_W 6 // retro port pad, already parsed

// ps2 event word layout, msb first
`define TI_EV_TOGGLE 10 // flips once per event
`define TI_EV_PRESSED 9 // 1 = make, 0 = break
`define TI_EV_EXT 8 // e0 prefix seen
`define TI_EV_CODE_W 8 // set-2 scan code

`endif

/* source/ti_pkg.sv */
// shared packed types; field order is msb first, so the last field of each struct is bit 0
`default_nettype none

package ti_pkg;

	// ===================================================================
	// keyboard side
	// ===================================================================

	typedef struct packed {
		logic toggle; // event marker
		logic pressed;
		logic ext;
		logic [7:0] code; // set-2 scan code
	} ps2_event_t;

	// one bit per held key, 52 in all
	typedef struct packed {
		logic num0, num1, num2, num3, num4, num5, num6, num7, num8, num9, eq;
		logic q, w, e, r, t, y, u, i, o, p, fs;
		logic a, s, d, f, g, h, j, k, l, se, en;
		logic sh, z, x, c, v, b, n, m, co, pe;
		logic al, ct, sp, fn; // al is the alpha lock latch
		logic kb_up, kb_down, kb_left, kb_right, kb_fire; // keyboard joystick
	} key_state_t;

	// ===================================================================
	// pad side
	// ===================================================================

	typedef struct packed {
		logic b9, b8, enter, b3, b2, b1;
		logic fire2, fire;
		logic up, down, left, right; // right is bit 0
	} joy_t;

	typedef struct packed {
		logic fire2, fire;
		logic up, down, left, right;
	} db_pad_t;

	typedef struct packed {
		logic up, down, left, right, fire;
	} stick_t;

	typedef struct packed {
		logic k1, k2, k3, k8, k9, enter, fn;
	} pad_keys_t;

	// ===================================================================
	// control and console side
	// ===================================================================

	typedef struct packed {
		logic joy_swap;
		logic db_enable;
		logic db_two_players;
		logic osd_active;
		logic spare; // reserved, drive zero
	} input_cfg_t;

	typedef struct packed {
		logic osd_reset, user_button, download; // all levels
	} reset_req_t;

	typedef struct packed {
		logic al_n; // alpha lock strobe
		logic [7:0] row_n;
	} scan_sel_t;

endpackage

`default_nettype wire

/* source/reset_ctrl.sv */
// console reset stays asserted from rst_n_i until the first download; requests are levels
`default_nettype none
`timescale 1ns/1ps

`include "ti_defs.svh"

module reset_ctrl import ti_pkg::*; (
	input  wire logic   CLK_50M,
	input  wire logic   rst_n_i,
	input  reset_req_t  reset_req_i,
	output logic        console_reset_o,
	output logic        flash_loading_o
);

	localparam logic [`TI_HOLD_W-1:0] HOLD_LOAD = `TI_HOLD_W'(`TI_HOLD_CYCLES);

	logic                  any_req;
	logic                  init_hold;
	logic [`TI_HOLD_W-1:0] hold_cnt;

	assign any_req = |reset_req_i;

	// ===================================================================
	// post download hold counter
	// ===================================================================

	always_ff @(posedge CLK_50M or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hold_cnt <= HOLD_LOAD; // loaded full, so flash loading shows out of reset
		end else if (any_req) begin
			hold_cnt <= HOLD_LOAD;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - `TI_HOLD_W'(1);
		end
	end

	assign flash_loading_o = (hold_cnt != '0);

	// machine waits for a rom image before it runs
	always_ff @(posedge CLK_50M or negedge rst_n_i) begin
		if (!rst_n_i) begin
			init_hold <= 1'b1;
		end else if (reset_req_i.download) begin
			init_hold <= 1'b0;
		end
	end

	assign console_reset_o = init_hold | any_req; // requests act in the same cycle

	// ===================================================================
	// checks
	// ===================================================================

	a_req_resets: assert property (@(posedge CLK_50M) disable iff (!rst_n_i)
		any_req |-> console_reset_o);

endmodule

`default_nettype wire

/* source/ps2_key_tracker.sv */
// set-2 codes only, extended flag ignored so e0 arrows alias the keypad codes; a missed toggle loses the event
`default_nettype none
`timescale 1ns/1ps

module ps2_key_tracker import ti_pkg::*; (
	input  wire logic  CLK_50M,
	input  wire logic  rst_n_i,
	input  ps2_event_t ps2_key_i,
	output key_state_t key_state_o
);

	logic       toggle_q;
	logic       event_w;
	logic       pressed_w;
	logic       caps_press_w;
	key_state_t key_q;

	assign event_w      = (ps2_key_i.toggle != toggle_q);
	assign pressed_w    = ps2_key_i.pressed;
	assign caps_press_w = event_w && pressed_w && (ps2_key_i.code == 8'h58);

	always_ff @(posedge CLK_50M or negedge rst_n_i) begin
		if (!rst_n_i) begin
			toggle_q <= 1'b0;
		end else begin
			toggle_q <= ps2_key_i.toggle;
		end
	end

	// ===================================================================
	// scan code decode
	// ===================================================================

	always_ff @(posedge CLK_50M or negedge rst_n_i) begin
		if (!rst_n_i) begin
			key_q <= '0; // everything released, alpha lock off
		end else if (event_w) begin
			case (ps2_key_i.code)
				8'h75: key_q.kb_up    <= pressed_w;
				8'h72: key_q.kb_down  <= pressed_w;
				8'h6B: key_q.kb_left  <= pressed_w;
				8'h74: key_q.kb_right <= pressed_w;
				8'h0E: key_q.kb_fire  <= pressed_w; // grave
				8'h16: key_q.num1     <= pressed_w;
				8'h1E: key_q.num2     <= pressed_w;
				8'h26: key_q.num3     <= pressed_w;
				8'h25: key_q.num4     <= pressed_w;
				8'h2E: key_q.num5     <= pressed_w;
				8'h36: key_q.num6     <= pressed_w;
				8'h3D: key_q.num7     <= pressed_w;
				8'h3E: key_q.num8     <= pressed_w;
				8'h46: key_q.num9     <= pressed_w;
				8'h45: key_q.num0     <= pressed_w;
				8'h4E, 8'h55, 8'h5D: key_q.eq <= pressed_w; // minus, equals, backslash
				8'h15: key_q.q        <= pressed_w;
				8'h1D: key_q.w        <= pressed_w;
				8'h24: key_q.e        <= pressed_w;
				8'h2D: key_q.r        <= pressed_w;
				8'h2C: key_q.t        <= pressed_w;
				8'h35: key_q.y        <= pressed_w;
				8'h3C: key_q.u        <= pressed_w;
				8'h43: key_q.i        <= pressed_w;
				8'h44: key_q.o        <= pressed_w;
				8'h4D: key_q.p        <= pressed_w;
				8'h54: key_q.fs       <= pressed_w; // left bracket stands in for slash
				8'h1C: key_q.a        <= pressed_w;
				8'h1B: key_q.s        <= pressed_w;
				8'h23: key_q.d        <= pressed_w;
				8'h2B: key_q.f        <= pressed_w;
				8'h34: key_q.g        <= pressed_w;
				8'h33: key_q.h        <= pressed_w;
				8'h3B: key_q.j        <= pressed_w;
				8'h42: key_q.k        <= pressed_w;
				8'h4B: key_q.l        <= pressed_w;
				8'h4C: key_q.se       <= pressed_w;
				8'h5A: key_q.en       <= pressed_w;
				8'h12, 8'h59: key_q.sh <= pressed_w; // either shift
				8'h1A: key_q.z        <= pressed_w;
				8'h22: key_q.x        <= pressed_w;
				8'h21: key_q.c        <= pressed_w;
				8'h2A: key_q.v        <= pressed_w;
				8'h32: key_q.b        <= pressed_w;
				8'h31: key_q.n        <= pressed_w;
				8'h3A: key_q.m        <= pressed_w;
				8'h41: key_q.co       <= pressed_w;
				8'h49: key_q.pe       <= pressed_w;
				8'h58: key_q.al       <= key_q.al ^ pressed_w; // caps lock flips on make only
				8'h14: key_q.ct       <= pressed_w;
				8'h29: key_q.sp       <= pressed_w;
				8'h11: key_q.fn       <= pressed_w; // left alt
				default: key_q <= key_q;
			endcase
		end
	end

	assign key_state_o = key_q;

	// alpha lock is a latch and must not drift with other traffic
	a_al_on_caps: assert property (@(posedge CLK_50M) disable iff (!rst_n_i)
		!$stable(key_q.al) |-> $past(caps_press_w));

endmodule

`default_nettype wire

/* source/joy_merge.sv */
// purely combinational; retro pads carry only directions and two fires, so their upper buttons read zero
`default_nettype none
`timescale 1ns/1ps

`include "ti_defs.svh"

module joy_merge import ti_pkg::*; (
	input  joy_t       joy_usb0_i,
	input  joy_t       joy_usb1_i,
	input  db_pad_t    joy_db1_i,
	input  db_pad_t    joy_db2_i,
	input  input_cfg_t cfg_i,
	output stick_t     stick1_o,
	output stick_t     stick2_o,
	output pad_keys_t  pad_keys_o
);

	logic [`TI_JOY_W-1:0] db1_ext;
	logic [`TI_JOY_W-1:0] db2_ext;
	joy_t                 pad_a_sel;
	joy_t                 pad_b_sel;
	joy_t                 pad_a;
	joy_t                 pad_b;

	// ===================================================================
	// source selection
	// ===================================================================

	// retro pads go quiet while the menu owns them
	assign db1_ext = cfg_i.osd_active ? '0 : {{(`TI_JOY_W-`TI_DB_W){1'b0}}, joy_db1_i};
	assign db2_ext = cfg_i.osd_active ? '0 : {{(`TI_JOY_W-`TI_DB_W){1'b0}}, joy_db2_i};

	always_comb begin
		if (cfg_i.db_enable) begin
			pad_a_sel = joy_t'(db1_ext);
			pad_b_sel = cfg_i.db_two_players ? joy_t'(db2_ext) : joy_usb0_i; // usb0 moves to B
		end else begin
			pad_a_sel = joy_usb0_i;
			pad_b_sel = joy_usb1_i;
		end
	end

	assign pad_a = cfg_i.joy_swap ? pad_b_sel : pad_a_sel;
	assign pad_b = cfg_i.joy_swap ? pad_a_sel : pad_b_sel;

	// ===================================================================
	// console sticks
	// ===================================================================

	// second fire of one pad acts as fire on the other player
	assign stick1_o.up    = pad_a.up;
	assign stick1_o.down  = pad_a.down;
	assign stick1_o.left  = pad_a.left;
	assign stick1_o.right = pad_a.right;
	assign stick1_o.fire  = pad_a.fire | pad_b.fire2;

	assign stick2_o.up    = pad_b.up;
	assign stick2_o.down  = pad_b.down;
	assign stick2_o.left  = pad_b.left;
	assign stick2_o.right = pad_b.right;
	assign stick2_o.fire  = pad_b.fire | pad_a.fire2;

	// ===================================================================
	// extra buttons as keys
	// ===================================================================

	assign pad_keys_o.k1    = pad_a.b1 | pad_b.b1; // menu picks in many carts
	assign pad_keys_o.k2    = pad_a.b2 | pad_b.b2;
	assign pad_keys_o.k3    = pad_a.b3 | pad_b.b3;
	assign pad_keys_o.k8    = pad_a.b8 | pad_b.b8;
	assign pad_keys_o.k9    = pad_a.b9 | pad_b.b9;
	assign pad_keys_o.enter = pad_a.enter | pad_b.enter;
	assign pad_keys_o.fn    = pad_a.b8 | pad_a.b9 | pad_b.b8 | pad_b.b9; // fn chords with 8 and 9

endmodule

`default_nettype wire

/* source/key_matrix.sv */
// combinational scan answer; strobes and column lines are active low, unused matrix cells read released
`default_nettype none
`timescale 1ns/1ps

`include "ti_defs.svh"

module key_matrix import ti_pkg::*; (
	input  key_state_t             key_state_i,
	input  stick_t                 stick1_i,
	input  stick_t                 stick2_i,
	input  pad_keys_t              pad_keys_i,
	input  scan_sel_t              scan_sel_i,
	output logic [`TI_KB_LINES-1:0] key_cols_o
);

	logic                    up1, down1, left1, right1, fire1;
	logic                    num1_m, num2_m, num3_m, num8_m, num9_m;
	logic                    en_m, fn_m;
	logic                    al_scan;
	logic [`TI_KB_LINES-1:0] row_sel;
	logic [`TI_KB_LINES-1:0] col_bits [`TI_KB_LINES];

	// ===================================================================
	// merge keyboard and pads
	// ===================================================================

	assign up1    = stick1_i.up    | key_state_i.kb_up;
	assign down1  = stick1_i.down  | key_state_i.kb_down;
	assign left1  = stick1_i.left  | key_state_i.kb_left;
	assign right1 = stick1_i.right | key_state_i.kb_right;
	assign fire1  = stick1_i.fire  | key_state_i.kb_fire;

	assign num1_m = key_state_i.num1 | pad_keys_i.k1;
	assign num2_m = key_state_i.num2 | pad_keys_i.k2;
	assign num3_m = key_state_i.num3 | pad_keys_i.k3;
	assign num8_m = key_state_i.num8 | pad_keys_i.k8;
	assign num9_m = key_state_i.num9 | pad_keys_i.k9;
	assign en_m   = key_state_i.en   | pad_keys_i.enter;
	assign fn_m   = key_state_i.fn   | pad_keys_i.fn;

	// ===================================================================
	// matrix, bit 7 down to bit 0
	// ===================================================================

	assign col_bits[0] = {key_state_i.eq, key_state_i.pe, key_state_i.co, key_state_i.m,
		key_state_i.n, key_state_i.fs, fire1, stick2_i.fire};
	assign col_bits[1] = {key_state_i.sp, key_state_i.l, key_state_i.k, key_state_i.j,
		key_state_i.h, key_state_i.se, left1, stick2_i.left};
	assign col_bits[2] = {en_m, key_state_i.o, key_state_i.i, key_state_i.u,
		key_state_i.y, key_state_i.p, right1, stick2_i.right};
	assign col_bits[3] = {1'b0, num9_m, num8_m, key_state_i.num7,
		key_state_i.num6, key_state_i.num0, down1, stick2_i.down};
	assign col_bits[4] = {fn_m, num2_m, num3_m, key_state_i.num4,
		key_state_i.num5, num1_m, up1, stick2_i.up};
	assign col_bits[5] = {key_state_i.sh, key_state_i.s, key_state_i.d, key_state_i.f,
		key_state_i.g, key_state_i.a, 2'b00};
	assign col_bits[6] = {key_state_i.ct, key_state_i.w, key_state_i.e, key_state_i.r,
		key_state_i.t, key_state_i.q, 2'b00};
	assign col_bits[7] = {1'b0, key_state_i.x, key_state_i.c, key_state_i.v,
		key_state_i.b, key_state_i.z, 2'b00};

	// upper nibble of strobes is wired in reverse order
	assign row_sel = ~{scan_sel_i.row_n[4], scan_sel_i.row_n[5], scan_sel_i.row_n[6],
		scan_sel_i.row_n[7], scan_sel_i.row_n[3:0]};

	assign al_scan = key_state_i.al & ~scan_sel_i.al_n; // alpha lock sits on column 4

	always_comb begin
		for (int c = 0; c < `TI_KB_LINES; c++) begin
			key_cols_o[c] = ~|(col_bits[c] & row_sel);
		end
		if (al_scan) begin
			key_cols_o[4] = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/ti_input_top.sv */
// input and reset side of the console top level; all inputs synchronous to CLK_50M, pads pre-parsed
`default_nettype none
`timescale 1ns/1ps

`include "ti_defs.svh"

module ti_input_top import ti_pkg::*; (
	input  wire logic               CLK_50M,
	input  wire logic               rst_n_i,
	input  ps2_event_t              ps2_key_i,
	input  joy_t                    joy_usb0_i,
	input  joy_t                    joy_usb1_i,
	input  db_pad_t                 joy_db1_i,
	input  db_pad_t                 joy_db2_i,
	input  input_cfg_t              cfg_i,
	input  reset_req_t              reset_req_i,
	input  scan_sel_t               scan_sel_i,
	output logic [`TI_KB_LINES-1:0] key_cols_o,
	output logic                    console_reset_o,
	output logic                    flash_loading_o
);

	key_state_t key_state;
	stick_t     stick1;
	stick_t     stick2;
	pad_keys_t  pad_keys;

	// ===================================================================
	// units
	// ===================================================================

	reset_ctrl u_reset_ctrl (
		.CLK_50M         (CLK_50M),
		.rst_n_i         (rst_n_i),
		.reset_req_i     (reset_req_i),
		.console_reset_o (console_reset_o),
		.flash_loading_o (flash_loading_o)
	);

	ps2_key_tracker u_ps2_key_tracker (
		.CLK_50M     (CLK_50M),
		.rst_n_i     (rst_n_i),
		.ps2_key_i   (ps2_key_i),
		.key_state_o (key_state)
	);

	joy_merge u_joy_merge (
		.joy_usb0_i (joy_usb0_i),
		.joy_usb1_i (joy_usb1_i),
		.joy_db1_i  (joy_db1_i),
		.joy_db2_i  (joy_db2_i),
		.cfg_i      (cfg_i),
		.stick1_o   (stick1),
		.stick2_o   (stick2),
		.pad_keys_o (pad_keys)
	);

	key_matrix u_key_matrix (
		.key_state_i (key_state),
		.stick1_i    (stick1),
		.stick2_i    (stick2),
		.pad_keys_i  (pad_keys),
		.scan_sel_i  (scan_sel_i),
		.key_cols_o  (key_cols_o)
	);

	// console strobes feed the matrix straight through, an X would reach every column
	a_scan_known: assert property (@(posedge CLK_50M) disable iff (!rst_n_i)
		!$isunknown(scan_sel_i));

endmodule

`default_nettype wire

/* verif/tb_ti_input.sv */
// drives ti_input_top from a row table; expected columns come from a model of the console matrix
`default_nettype none
`timescale 1ns/1ps

`include "ti_defs.svh"

module tb_ti_input import ti_pkg::*; ();

	typedef struct {
		logic       has_ev;
		logic [7:0] code;
		logic       pressed;
		input_cfg_t cfg;
		joy_t       u0;
		joy_t       u1;
		db_pad_t    d1;
		db_pad_t    d2;
		reset_req_t req;
	} row_t;

	logic                    CLK_50M;
	logic                    rst_n_i;
	ps2_event_t              ps2_key;
	joy_t                    joy_usb0, joy_usb1;
	db_pad_t                 joy_db1, joy_db2;
	input_cfg_t              cfg;
	reset_req_t              reset_req;
	scan_sel_t               scan_sel;
	logic [`TI_KB_LINES-1:0] key_cols;
	logic                    console_reset, flash_loading;

	row_t                    rows[$];
	logic                    table_built = 1'b0;
	logic [7:0]              kbm [8]; // keyboard cells, [column][bit]
	logic [7:0]              pcm [8]; // pad cells
	logic                    al_m;
	int                      n_checks = 0;
	int                      err_cols = 0;
	int                      err_ctrl = 0;

	ti_input_top u_dut (
		.CLK_50M         (CLK_50M),
		.rst_n_i         (rst_n_i),
		.ps2_key_i       (ps2_key),
		.joy_usb0_i      (joy_usb0),
		.joy_usb1_i      (joy_usb1),
		.joy_db1_i       (joy_db1),
		.joy_db2_i       (joy_db2),
		.cfg_i           (cfg),
		.reset_req_i     (reset_req),
		.scan_sel_i      (scan_sel),
		.key_cols_o      (key_cols),
		.console_reset_o (console_reset),
		.flash_loading_o (flash_loading)
	);

	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	// ===================================================================
	// reference model
	// ===================================================================

	// {valid, column, bit} of a set-2 code
	function automatic logic [6:0] key_pos(input logic [7:0] code);
		case (code)
			8'h4E, 8'h55, 8'h5D: return {1'b1, 3'd0, 3'd7}; // eq and its aliases
			8'h49: return {1'b1, 3'd0, 3'd6};
			8'h41: return {1'b1, 3'd0, 3'd5};
			8'h3A: return {1'b1, 3'd0, 3'd4};
			8'h31: return {1'b1, 3'd0, 3'd3};
			8'h54: return {1'b1, 3'd0, 3'd2};
			8'h0E: return {1'b1, 3'd0, 3'd1}; // keyboard fire
			8'h29: return {1'b1, 3'd1, 3'd7};
			8'h4B: return {1'b1, 3'd1, 3'd6};
			8'h42: return {1'b1, 3'd1, 3'd5};
			8'h3B: return {1'b1, 3'd1, 3'd4};
			8'h33: return {1'b1, 3'd1, 3'd3};
			8'h4C: return {1'b1, 3'd1, 3'd2};
			8'h6B: return {1'b1, 3'd1, 3'd1};
			8'h5A: return {1'b1, 3'd2, 3'd7};
			8'h44: return {1'b1, 3'd2, 3'd6};
			8'h43: return {1'b1, 3'd2, 3'd5};
			8'h3C: return {1'b1, 3'd2, 3'd4};
			8'h35: return {1'b1, 3'd2, 3'd3};
			8'h4D: return {1'b1, 3'd2, 3'd2};
			8'h74: return {1'b1, 3'd2, 3'd1};
			8'h46: return {1'b1, 3'd3, 3'd6};
			8'h3E: return {1'b1, 3'd3, 3'd5};
			8'h3D: return {1'b1, 3'd3, 3'd4};
			8'h36: return {1'b1, 3'd3, 3'd3};
			8'h45: return {1'b1, 3'd3, 3'd2};
			8'h72: return {1'b1, 3'd3, 3'd1};
			8'h11: return {1'b1, 3'd4, 3'd7};
			8'h1E: return {1'b1, 3'd4, 3'd6};
			8'h26: return {1'b1, 3'd4, 3'd5};
			8'h25: return {1'b1, 3'd4, 3'd4};
			8'h2E: return {1'b1, 3'd4, 3'd3};
			8'h16: return {1'b1, 3'd4, 3'd2};
			8'h75: return {1'b1, 3'd4, 3'd1};
			8'h12, 8'h59: return {1'b1, 3'd5, 3'd7}; // both shifts
			8'h1B: return {1'b1, 3'd5, 3'd6};
			8'h23: return {1'b1, 3'd5, 3'd5};
			8'h2B: return {1'b1, 3'd5, 3'd4};
			8'h34: return {1'b1, 3'd5, 3'd3};
			8'h1C: return {1'b1, 3'd5, 3'd2};
			8'h14: return {1'b1, 3'd6, 3'd7};
			8'h1D: return {1'b1, 3'd6, 3'd6};
			8'h24: return {1'b1, 3'd6, 3'd5};
			8'h2D: return {1'b1, 3'd6, 3'd4};
			8'h2C: return {1'b1, 3'd6, 3'd3};
			8'h15: return {1'b1, 3'd6, 3'd2};
			8'h22: return {1'b1, 3'd7, 3'd6};
			8'h21: return {1'b1, 3'd7, 3'd5};
			8'h2A: return {1'b1, 3'd7, 3'd4};
			8'h32: return {1'b1, 3'd7, 3'd3};
			8'h1A: return {1'b1, 3'd7, 3'd2};
			default: return 7'd0;
		endcase
	endfunction

	task automatic model_event(input logic [7:0] code, input logic pressed);
		logic [6:0] pos;
		pos = key_pos(code);
		if (code == 8'h58) begin
			al_m = al_m ^ pressed; // make toggles, break ignored
		end else if (pos[6]) begin
			kbm[pos[5:3]][pos[2:0]] = pressed;
		end
	endtask

	// pad bits: right, left, down, up, fire, fire2, b1, b2, b3, enter, b8, b9 from bit 0
	task automatic model_pads(input row_t r);
		logic [11:0] a, b, d1x, d2x, t;
		d1x = r.cfg.osd_active ? 12'd0 : {6'd0, r.d1};
		d2x = r.cfg.osd_active ? 12'd0 : {6'd0, r.d2};
		if (r.cfg.db_enable) begin
			a = d1x;
			b = r.cfg.db_two_players ? d2x : r.u0;
		end else begin
			a = r.u0;
			b = r.u1;
		end
		if (r.cfg.joy_swap) begin
			t = a;
			a = b;
			b = t;
		end
		for (int c = 0; c < 8; c++) pcm[c] = 8'd0;
		pcm[0][1] = a[4] | b[5]; // crossed fires
		pcm[0][0] = b[4] | a[5];
		pcm[1][1] = a[1];
		pcm[1][0] = b[1];
		pcm[2][1] = a[0];
		pcm[2][0] = b[0];
		pcm[3][1] = a[2];
		pcm[3][0] = b[2];
		pcm[4][1] = a[3];
		pcm[4][0] = b[3];
		pcm[4][2] = a[6] | b[6];
		pcm[4][6] = a[7] | b[7];
		pcm[4][5] = a[8] | b[8];
		pcm[3][5] = a[10] | b[10];
		pcm[3][6] = a[11] | b[11];
		pcm[2][7] = a[9] | b[9];
		pcm[4][7] = a[10] | a[11] | b[10] | b[11]; // fn
	endtask

	function automatic logic [`TI_KB_LINES-1:0] exp_cols(input scan_sel_t sel);
		logic [`TI_KB_LINES-1:0] cols;
		int                      strobe;
		cols = '1;
		for (int c = 0; c < 8; c++) begin
			for (int b = 0; b < 8; b++) begin
				strobe = (b >= 4) ? 11 - b : b; // upper nibble reversed
				if ((kbm[c][b] | pcm[c][b]) && !sel.row_n[strobe]) cols[c] = 1'b0;
			end
		end
		if (al_m && !sel.al_n) cols[4] = 1'b0;
		return cols;
	endfunction

	// ===================================================================
	// checks
	// ===================================================================

	task automatic check_cols(input logic [`TI_KB_LINES-1:0] got, input logic [`TI_KB_LINES-1:0] exp,
		input scan_sel_t sel);
		n_checks++;
		if (got !== exp) begin
			err_cols++;
			$display("mismatch at %0t: key_cols_o got %b expected %b (scan %b)", $time, got, exp, sel);
		end
	endtask

	task automatic check_ctrl(input logic got_rst, input logic got_fl, input logic exp_rst,
		input logic exp_fl);
		n_checks++;
		if (got_rst !== exp_rst) begin
			err_ctrl++;
			$display("mismatch at %0t: console_reset_o got %b expected %b", $time, got_rst, exp_rst);
		end
		if (got_fl !== exp_fl) begin
			err_ctrl++;
			$display("mismatch at %0t: flash_loading_o got %b expected %b", $time, got_fl, exp_fl);
		end
	endtask

	// ===================================================================
	// stimulus
	// ===================================================================

	task automatic add_row(input logic has_ev, input logic [7:0] code, input logic pressed,
		input logic [4:0] cfg_bits, input logic [11:0] u0, input logic [11:0] u1,
		input logic [5:0] d1, input logic [5:0] d2);
		row_t r;
		r.has_ev  = has_ev;
		r.code    = code;
		r.pressed = pressed;
		r.cfg     = input_cfg_t'(cfg_bits);
		r.u0      = joy_t'(u0);
		r.u1      = joy_t'(u1);
		r.d1      = db_pad_t'(d1);
		r.d2      = db_pad_t'(d2);
		r.req     = '0;
		rows.push_back(r);
	endtask

	task automatic key_row(input logic [7:0] code, input logic pressed);
		add_row(1'b1, code, pressed, 5'd0, 12'd0, 12'd0, 6'd0, 6'd0);
	endtask

	// entered at 2 ns after an edge, leaves at the same point
	task automatic apply_row(input row_t r);
		cfg       = r.cfg;
		joy_usb0  = r.u0;
		joy_usb1  = r.u1;
		joy_db1   = r.d1;
		joy_db2   = r.d2;
		reset_req = r.req;
		scan_sel  = '1;
		if (r.has_ev) begin
			ps2_key.toggle  = ~ps2_key.toggle;
			ps2_key.pressed = r.pressed;
			ps2_key.ext     = 1'($urandom);
			ps2_key.code    = r.code;
		end
		model_pads(r);
		@(posedge CLK_50M);
		if (r.has_ev) model_event(r.code, r.pressed);
		#2;
		for (int s = 0; s < 10; s++) begin
			if (s < 8) scan_sel = {1'b1, ~(8'd1 << s)};
			else if (s == 8) scan_sel = {1'b1, 8'h00};
			else scan_sel = {1'b0, 8'hFF}; // alpha lock strobe alone
			#10;
			check_cols(key_cols, exp_cols(scan_sel), scan_sel);
			@(posedge CLK_50M);
			#2;
		end
	endtask

	// fl_before is the hold state going in, the reload only shows after the edge
	task automatic pulse_req(input reset_req_t r, input logic fl_before);
		reset_req = r;
		#10;
		check_ctrl(console_reset, flash_loading, 1'b1, fl_before);
		@(posedge CLK_50M);
		#2;
		reset_req = '0;
		#10;
		check_ctrl(console_reset, flash_loading, 1'b0, 1'b1);
		@(posedge CLK_50M);
		#2;
	endtask

	task automatic build_table();
		logic [4:0] c;
		key_row(8'h1C, 1'b1); // a
		key_row(8'h16, 1'b1);
		key_row(8'h45, 1'b1);
		key_row(8'h1C, 1'b0);
		key_row(8'h45, 1'b0);
		key_row(8'h16, 1'b0);
		key_row(8'h29, 1'b1);
		key_row(8'h3A, 1'b1);
		key_row(8'h22, 1'b1);
		key_row(8'h14, 1'b1);
		key_row(8'h29, 1'b0);
		key_row(8'h3A, 1'b0);
		key_row(8'h22, 1'b0);
		key_row(8'h14, 1'b0);
		key_row(8'h4E, 1'b1); // minus, equals, backslash
		key_row(8'h4E, 1'b0);
		key_row(8'h55, 1'b1);
		key_row(8'h55, 1'b0);
		key_row(8'h5D, 1'b1);
		key_row(8'h5D, 1'b0);
		key_row(8'h12, 1'b1);
		key_row(8'h12, 1'b0);
		key_row(8'h59, 1'b1);
		key_row(8'h59, 1'b0);
		key_row(8'h58, 1'b1); // caps lock on
		key_row(8'h58, 1'b0);
		key_row(8'h58, 1'b1);
		key_row(8'h58, 1'b0);
		key_row(8'h07, 1'b1); // unknown
		for (int i = 0; i < 16; i++) begin
			c = {i[0], i[1], i[2], 2'b00}; // swap, db_enable, two players
			add_row(1'b0, 8'h00, 1'b0, c, 12'($urandom), 12'($urandom), 6'($urandom),
				6'($urandom));
		end
		add_row(1'b0, 8'h00, 1'b0, 5'b01110, 12'($urandom), 12'($urandom), 6'h3F, 6'h3F);
		add_row(1'b0, 8'h00, 1'b0, 5'b00010, 12'hFFF, 12'hFFF, 6'h3F, 6'h3F);
		add_row(1'b1, 8'h75, 1'b1, 5'd0, 12'h008, 12'd0, 6'd0, 6'd0); // arrow and pad up
		add_row(1'b1, 8'h75, 1'b0, 5'd0, 12'h008, 12'd0, 6'd0, 6'd0);
		add_row(1'b1, 8'h16, 1'b1, 5'd0, 12'h040, 12'd0, 6'd0, 6'd0); // digit and b1
		add_row(1'b1, 8'h16, 1'b0, 5'd0, 12'h040, 12'd0, 6'd0, 6'd0);
		add_row(1'b1, 8'h75, 1'b1, 5'd0, 12'd0, 12'd0, 6'd0, 6'd0);
		key_row(8'h75, 1'b0);
	endtask

	// ===================================================================
	// main sequence and watchdog
	// ===================================================================

	initial begin
		void'($urandom(78198));
		rst_n_i   = 1'b0;
		ps2_key   = '0;
		joy_usb0  = '0;
		joy_usb1  = '0;
		joy_db1   = '0;
		joy_db2   = '0;
		cfg       = '0;
		reset_req = '0;
		scan_sel  = '1;
		al_m      = 1'b0;
		for (int c = 0; c < 8; c++) begin
			kbm[c] = 8'd0;
			pcm[c] = 8'd0;
		end
		build_table();
		table_built = 1'b1;
		repeat (2) @(posedge CLK_50M);
		#2;
		rst_n_i = 1'b1;
		check_ctrl(console_reset, flash_loading, 1'b1, 1'b1);
		reset_req = 3'b001; // first download
		#10;
		check_ctrl(console_reset, flash_loading, 1'b1, 1'b1);
		@(posedge CLK_50M);
		#2;
		reset_req = '0;
		#10;
		check_ctrl(console_reset, flash_loading, 1'b0, 1'b1);
		repeat (`TI_HOLD_CYCLES - 1) @(posedge CLK_50M);
		#2;
		check_ctrl(console_reset, flash_loading, 1'b0, 1'b1);
		@(posedge CLK_50M);
		#2;
		check_ctrl(console_reset, flash_loading, 1'b0, 1'b0);
		pulse_req(3'b100, 1'b0); // hold has run out
		pulse_req(3'b010, 1'b1); // still counting down from the osd reset
		foreach (rows[i]) apply_row(rows[i]);
		$display("checks %0d, column errors %0d, control errors %0d", n_checks, err_cols, err_ctrl);
		if (err_cols + err_ctrl == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		wait (table_built);
		repeat (rows.size() * 16 + 2 * `TI_HOLD_CYCLES + 100) @(posedge CLK_50M);
		$display("timeout: the test sequence did not finish in time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
source/ti_pkg.sv
source/reset_ctrl.sv
source/ps2_key_tracker.sv
source/joy_merge.sv
source/key_matrix.sv
source/ti_input_top.sv
verif/tb_ti_input.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_ti_input
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
